/* hw/qdr_phy_cfg_pkg.sv */
// ==========================================================
// fixed read path constants; changing a width here changes every block
// CAL_ADDR is reserved and must hold CAL_PATTERN in the memory
// ==========================================================

package qdr_phy_cfg_pkg;

	// width of the latency count driven to the read valid selector
	localparam int MAX_LATENCY_COUNT_WIDTH = 4;
	// number of selectable latencies, one history bit per latency
	localparam int LATENCY_NUM = 2 ** MAX_LATENCY_COUNT_WIDTH;

	// read address and data widths of the memory interface
	localparam int RD_ADDR_WIDTH = 20;
	localparam int RD_DATA_WIDTH = 18;

	// the calibration word lives at the top of the address space
	localparam logic [RD_ADDR_WIDTH-1:0] CAL_ADDR = '1;
	localparam logic [RD_DATA_WIDTH-1:0] CAL_PATTERN = 18'h25A3C;

	// a sweep read is retired once its strobe has left the history
	localparam int CAL_WAIT = LATENCY_NUM + 4;
	// spacing of the tracking reads after lock
	localparam int TRACK_INTERVAL = 64;
	// depth of the router tag queue, bounds the reads in flight
	localparam int TAG_DEPTH = 16;

endpackage

/* hw/qdr_rd_types_pkg.sv */
// ==========================================================
// types shared by the read path blocks, sized from qdr_phy_cfg_pkg
// ==========================================================

package qdr_rd_types_pkg;

	import qdr_phy_cfg_pkg::*;

	// calibrated latency count
	typedef logic [MAX_LATENCY_COUNT_WIDTH-1:0] lat_cnt_t;
	// strobe history and the one-hot latency select share this width
	typedef logic [LATENCY_NUM-1:0] lat_vec_t;
	typedef logic [RD_ADDR_WIDTH-1:0] rd_addr_t;
	typedef logic [RD_DATA_WIDTH-1:0] rd_data_t;

	// who issued a read, carried with the command and kept in the tag queue
	typedef enum logic {
		REQ_CAL  = 1'b0,
		REQ_USER = 1'b1
	} requester_t;

	// one read command on the shared bus, the strobe is a single cycle pulse
	typedef struct packed {
		logic       strobe;
		rd_addr_t   addr;
		requester_t requester;
	} rd_cmd_t;

	// calibrator states, the sweep pair runs once per latency count
	typedef enum logic [2:0] {
		CAL_SWEEP_ISSUE,
		CAL_SWEEP_WAIT,
		CAL_LOCKED,
		CAL_TRACK_WAIT,
		CAL_FAIL
	} cal_state_t;

endpackage

/* hw/read_latency_shifter.sv */
// ==========================================================
// history is LATENCY_NUM deep, older strobes fall off the top
// ==========================================================

module read_latency_shifter
	import qdr_rd_types_pkg::*;
(
	input  logic     reset_n,
	input  logic     pll_afi_clk,
	input  logic     rd_strobe,
	output lat_vec_t latency_shifter
);

	// bit 0 takes the strobe seen on the bus in the previous cycle
	// so bit k is set k+1 cycles after the command was on the bus
	// each higher bit is one cycle older than the bit below it
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[$bits(lat_vec_t)-2:0], rd_strobe};
		end
	end

	// the history is a plain shift, nothing clears it except reset
	// a strobe therefore lives for exactly LATENCY_NUM cycles

endmodule

/* hw/read_valid_selector.sv */
// ==========================================================
// latency_counter should stay stable while reads are in flight
// ==========================================================

module read_valid_selector
	import qdr_rd_types_pkg::*;
(
	input  logic     reset_n,
	input  logic     pll_afi_clk,
	input  lat_vec_t latency_shifter,
	input  lat_cnt_t latency_counter,
	output logic     read_enable,
	output logic     read_valid
);

	lat_vec_t selector;
	lat_vec_t selector_reg;
	lat_vec_t valid_select;

	// one-hot decode of the latency count
	assign selector = lat_vec_t'(1) << latency_counter;

	// the decode is registered so the count never sits in the mask path
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			selector_reg <= '0;
		end
		else
		begin
			selector_reg <= selector;
		end
	end

	// only the history bit at the selected latency can raise a pulse
	assign valid_select = selector_reg & latency_shifter;

	// read_enable goes out as the capture enable, read_valid pops the router
	// both carry the same registered pulse
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			read_enable <= 1'b0;
			read_valid <= 1'b0;
		end
		else
		begin
			read_enable <= |valid_select;
			read_valid <= |valid_select;
		end
	end

endmodule

/* hw/read_latency_calibrator.sv */
// ==========================================================
// issues at most one read every other cycle; a failed sweep stays in CAL_FAIL
// cal_error is sticky until reset, cal_done is never dropped after lock
// ==========================================================

module read_latency_calibrator
	import qdr_phy_cfg_pkg::*, qdr_rd_types_pkg::*;
(
	input  logic     reset_n,
	input  logic     pll_afi_clk,
	output rd_cmd_t  cal_cmd,
	input  logic     cal_rd_valid,
	input  rd_data_t cal_rd_data,
	output lat_cnt_t latency_counter,
	output logic     queue_flush,
	output logic     cal_done,
	output logic     cal_error
);

	cal_state_t state;
	// counts both the sweep wait and the tracking interval
	logic [$clog2(TRACK_INTERVAL):0] timer;
	logic track_issue;
	logic beat_match;

	// the tracking read goes out on the last cycle of each interval
	assign track_issue = (state == CAL_LOCKED) && (timer == TRACK_INTERVAL - 1);
	assign beat_match = cal_rd_valid && (cal_rd_data == CAL_PATTERN);

	// the calibrator only ever reads the reserved word
	assign cal_cmd.strobe = (state == CAL_SWEEP_ISSUE) || track_issue;
	assign cal_cmd.addr = CAL_ADDR;
	assign cal_cmd.requester = REQ_CAL;

	// stray tags from wrong-count pulses are dropped at every sweep step
	assign queue_flush = (state == CAL_SWEEP_ISSUE);

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= CAL_SWEEP_ISSUE;
			timer <= '0;
			latency_counter <= '0;
			cal_done <= 1'b0;
			cal_error <= 1'b0;
		end
		else
		begin
			timer <= timer + 1'b1;
			case (state)
				CAL_SWEEP_ISSUE:
				begin
					timer <= '0;
					state <= CAL_SWEEP_WAIT;
				end
				CAL_SWEEP_WAIT:
				begin
					// a mismatching pulse at a wrong count is simply ignored
					if (beat_match)
					begin
						timer <= '0;
						cal_done <= 1'b1;
						state <= CAL_LOCKED;
					end
					else if (timer == CAL_WAIT - 1)
					begin
						if (latency_counter == lat_cnt_t'(LATENCY_NUM - 1))
						begin
							cal_error <= 1'b1;
							state <= CAL_FAIL;
						end
						else
						begin
							latency_counter <= latency_counter + 1'b1;
							state <= CAL_SWEEP_ISSUE;
						end
					end
				end
				CAL_LOCKED:
				begin
					if (track_issue)
					begin
						timer <= '0;
						state <= CAL_TRACK_WAIT;
					end
				end
				CAL_TRACK_WAIT:
				begin
					// the timer keeps running so the next read stays on the interval
					if (cal_rd_valid)
					begin
						if (!beat_match)
							cal_error <= 1'b1;
						state <= CAL_LOCKED;
					end
					else if (timer == CAL_WAIT - 1)
					begin
						// the tracking beat never showed up at the locked count
						cal_error <= 1'b1;
						state <= CAL_LOCKED;
					end
				end
				CAL_FAIL:
				begin
					state <= CAL_FAIL;
				end
				default:
				begin
					state <= CAL_FAIL;
				end
			endcase
		end
	end

endmodule

/* hw/read_cmd_arbiter.sv */
// ==========================================================
// relies on the calibrator never issuing on two cycles in a row
// user strobes before cal_done are dropped, not queued
// ==========================================================

module read_cmd_arbiter
	import qdr_rd_types_pkg::*;
(
	input  logic    reset_n,
	input  logic    pll_afi_clk,
	input  rd_cmd_t cal_cmd,
	input  rd_cmd_t user_cmd,
	input  logic    cal_done,
	output rd_cmd_t mem_rd_cmd
);

	logic     user_req;
	logic     pending_valid;
	rd_addr_t pending_addr;

	// the user port is dead until calibration has locked
	assign user_req = user_cmd.strobe && cal_done;

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			mem_rd_cmd <= '0;
			pending_valid <= 1'b0;
			pending_addr <= '0;
		end
		else
		begin
			if (cal_cmd.strobe)
			begin
				// calibrator wins, a colliding user read parks in the slot
				mem_rd_cmd <= '{strobe: 1'b1, addr: cal_cmd.addr, requester: REQ_CAL};
				if (user_req)
				begin
					pending_valid <= 1'b1;
					pending_addr <= user_cmd.addr;
				end
			end
			else if (pending_valid)
			begin
				// the parked read goes before any new user read
				mem_rd_cmd <= '{strobe: 1'b1, addr: pending_addr, requester: REQ_USER};
				pending_valid <= user_req;
				if (user_req)
					pending_addr <= user_cmd.addr;
			end
			else if (user_req)
			begin
				mem_rd_cmd <= '{strobe: 1'b1, addr: user_cmd.addr, requester: REQ_USER};
			end
			else
			begin
				mem_rd_cmd.strobe <= 1'b0;
			end
		end
	end

endmodule

/* hw/read_data_router.sv */
// ==========================================================
// at most TAG_DEPTH reads in flight; a push into a full queue is lost
// ==========================================================

module read_data_router
	import qdr_phy_cfg_pkg::*, qdr_rd_types_pkg::*;
(
	input  logic     reset_n,
	input  logic     pll_afi_clk,
	input  rd_cmd_t  mem_rd_cmd,
	input  logic     read_valid,
	input  rd_data_t mem_rd_data,
	input  logic     queue_flush,
	output logic     cal_rd_valid,
	output rd_data_t cal_rd_data,
	output logic     user_rd_valid,
	output rd_data_t user_rd_data
);

	requester_t tag_mem [TAG_DEPTH];
	logic [$clog2(TAG_DEPTH)-1:0] wr_ptr;
	logic [$clog2(TAG_DEPTH)-1:0] rd_ptr;
	logic [$clog2(TAG_DEPTH):0] tag_count;
	logic queue_full;
	logic push;
	logic pop;
	requester_t head_tag;

	assign queue_full = (tag_count == TAG_DEPTH);
	assign push = mem_rd_cmd.strobe && !queue_full;
	// a pulse with no read behind it pops nothing and goes nowhere
	assign pop = read_valid && (tag_count != '0);
	// returns keep issue order, so the oldest tag owns the current beat
	assign head_tag = tag_mem[rd_ptr];

	always_ff @(posedge pll_afi_clk)
	begin
		if (push)
			tag_mem[wr_ptr] <= mem_rd_cmd.requester;
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			tag_count <= '0;
		end
		else if (queue_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			tag_count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				tag_count <= tag_count + 1'b1;
			else if (pop && !push)
				tag_count <= tag_count - 1'b1;
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cal_rd_valid <= 1'b0;
			user_rd_valid <= 1'b0;
		end
		else
		begin
			cal_rd_valid <= pop && (head_tag == REQ_CAL);
			user_rd_valid <= pop && (head_tag == REQ_USER);
		end
	end

	// the data word passes through untouched, one register behind the pop
	always_ff @(posedge pll_afi_clk)
	begin
		if (pop && (head_tag == REQ_CAL))
			cal_rd_data <= mem_rd_data;
		if (pop && (head_tag == REQ_USER))
			user_rd_data <= mem_rd_data;
	end

endmodule

/* hw/qdr_read_path_top.sv */
// ==========================================================
// user reads are accepted only while cal_done is high
// ==========================================================

module qdr_read_path_top
	import qdr_rd_types_pkg::*;
(
	input  logic     reset_n,
	input  logic     pll_afi_clk,
	input  logic     user_rd_strobe,
	input  rd_addr_t user_rd_addr,
	output rd_cmd_t  mem_rd_cmd,
	input  rd_data_t mem_rd_data,
	output logic     read_enable,
	output logic     user_rd_valid,
	output rd_data_t user_rd_data,
	output logic     cal_done,
	output logic     cal_error
);

	rd_cmd_t  cal_cmd;
	rd_cmd_t  user_cmd;
	lat_vec_t latency_shifter;
	lat_cnt_t latency_counter;
	logic     read_valid;
	logic     queue_flush;
	logic     cal_rd_valid;
	rd_data_t cal_rd_data;

	// the user port arrives as loose strobe and address
	assign user_cmd = '{strobe: user_rd_strobe, addr: user_rd_addr, requester: REQ_USER};

	read_latency_calibrator u_calibrator (
		.reset_n         (reset_n),
		.pll_afi_clk     (pll_afi_clk),
		.cal_cmd         (cal_cmd),
		.cal_rd_valid    (cal_rd_valid),
		.cal_rd_data     (cal_rd_data),
		.latency_counter (latency_counter),
		.queue_flush     (queue_flush),
		.cal_done        (cal_done),
		.cal_error       (cal_error)
	);

	read_cmd_arbiter u_arbiter (
		.reset_n     (reset_n),
		.pll_afi_clk (pll_afi_clk),
		.cal_cmd     (cal_cmd),
		.user_cmd    (user_cmd),
		.cal_done    (cal_done),
		.mem_rd_cmd  (mem_rd_cmd)
	);

	read_latency_shifter u_shifter (
		.reset_n         (reset_n),
		.pll_afi_clk     (pll_afi_clk),
		.rd_strobe       (mem_rd_cmd.strobe),
		.latency_shifter (latency_shifter)
	);

	read_valid_selector u_selector (
		.reset_n         (reset_n),
		.pll_afi_clk     (pll_afi_clk),
		.latency_shifter (latency_shifter),
		.latency_counter (latency_counter),
		.read_enable     (read_enable),
		.read_valid      (read_valid)
	);

	read_data_router u_router (
		.reset_n       (reset_n),
		.pll_afi_clk   (pll_afi_clk),
		.mem_rd_cmd    (mem_rd_cmd),
		.read_valid    (read_valid),
		.mem_rd_data   (mem_rd_data),
		.queue_flush   (queue_flush),
		.cal_rd_valid  (cal_rd_valid),
		.cal_rd_data   (cal_rd_data),
		.user_rd_valid (user_rd_valid),
		.user_rd_data  (user_rd_data)
	);

endmodule

/* bench/qdr_read_path_properties.sv */
// ==========================================================
// bound into qdr_read_path_top, reaches the router queue by hierarchy
// ==========================================================

module qdr_read_path_properties
	import qdr_rd_types_pkg::*;
(
	input logic    reset_n,
	input logic    pll_afi_clk,
	input rd_cmd_t mem_rd_cmd,
	input logic    queue_full,
	input logic    read_enable,
	input logic    read_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// the pending slot only drains if the calibrator leaves a gap after each grant
	cal_grant_gap: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		(mem_rd_cmd.strobe && mem_rd_cmd.requester == REQ_CAL)
		|=> !(mem_rd_cmd.strobe && mem_rd_cmd.requester == REQ_CAL))
		else $error("calibrator granted the bus on two cycles in a row");

	// a tag pushed into a full queue would be lost
	no_push_when_full: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		!(mem_rd_cmd.strobe && queue_full))
		else $error("bus strobe while the router tag queue is full");

	// both selector outputs carry the same registered pulse
	enable_equals_valid: assert property (@(posedge pll_afi_clk) disable iff (!reset_n)
		read_enable == read_valid)
		else $error("read_enable differs from read_valid");

endmodule

bind qdr_read_path_top qdr_read_path_properties u_properties (
	.reset_n     (reset_n),
	.pll_afi_clk (pll_afi_clk),
	.mem_rd_cmd  (mem_rd_cmd),
	.queue_full  (u_router.queue_full),
	.read_enable (read_enable),
	.read_valid  (read_valid)
);

/* bench/qdr_read_path_tb.sv */
// ==========================================================
// memory model returns a read mem_latency cycles after the bus command
// mem_latency must be at least 2, words are drawn lazily per address
// ==========================================================

module qdr_read_path_tb
	import qdr_phy_cfg_pkg::*, qdr_rd_types_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CAL_LIMIT = LATENCY_NUM * CAL_WAIT * 2;
	// two calibrations, the user traffic and a margin for the drains
	localparam int RUN_LIMIT = 3 * CAL_LIMIT + 8 * TRACK_INTERVAL + 600;

	logic     reset_n;
	logic     pll_afi_clk;
	logic     user_rd_strobe;
	rd_addr_t user_rd_addr;
	rd_cmd_t  mem_rd_cmd;
	rd_data_t mem_rd_data;
	logic     read_enable;
	logic     user_rd_valid;
	rd_data_t user_rd_data;
	logic     cal_done;
	logic     cal_error;

	rd_data_t mem [rd_addr_t];
	rd_cmd_t  hist [32];
	rd_data_t exp_q [$];
	int       mem_latency;
	int       errors;
	int       cycles;
	int       user_bus_cmds;
	string    test_name;

	qdr_read_path_top dut (.*);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #10 pll_afi_clk = ~pll_afi_clk;
	end

	// unwritten words are drawn on first touch, the calibration word is fixed
	function automatic rd_data_t read_word(rd_addr_t a);
		if (a == CAL_ADDR)
			return CAL_PATTERN;
		if (!mem.exists(a))
			mem[a] = rd_data_t'($urandom);
		return mem[a];
	endfunction

	// hist[k] holds the command seen on the bus k+1 cycles before this edge
	always @(posedge pll_afi_clk)
	begin
		if (!reset_n)
		begin
			foreach (hist[i])
				hist[i] = '0;
			mem_rd_data <= '0;
		end
		else
		begin
			if (hist[mem_latency-2].strobe)
				mem_rd_data <= read_word(hist[mem_latency-2].addr);
			else
				mem_rd_data <= '0;
			for (int i = 31; i > 0; i--)
				hist[i] = hist[i-1];
			hist[0] = mem_rd_cmd;
		end
	end

	// every user beat is compared with the oldest outstanding expected word
	always @(posedge pll_afi_clk)
	begin
		if (reset_n && user_rd_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("%s: user_rd_valid with no read outstanding", test_name);
				errors++;
			end
			else if (user_rd_data != exp_q[0])
			begin
				$display("mismatch %s: expected %h actual %h", test_name, exp_q[0], user_rd_data);
				errors++;
				void'(exp_q.pop_front());
			end
			else
			begin
				void'(exp_q.pop_front());
			end
		end
		if (reset_n && mem_rd_cmd.strobe && mem_rd_cmd.requester == REQ_USER)
			user_bus_cmds++;
	end

	always @(posedge pll_afi_clk)
	begin
		cycles++;
		if (cycles >= RUN_LIMIT)
		begin
			$display("timeout: run exceeded %0d cycles in %s", RUN_LIMIT, test_name);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic apply_reset();
		reset_n <= 1'b0;
		user_rd_strobe <= 1'b0;
		exp_q.delete();
		repeat (3) @(posedge pll_afi_clk);
		reset_n <= 1'b1;
	endtask

	task automatic check_bit(string what, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("mismatch %s: %s expected %b actual %b", test_name, what, expected, actual);
			errors++;
		end
	endtask

	// waits until cal_done or cal_error is high, or the limit runs out
	task automatic wait_cal(logic want_error, int limit);
		int n;
		n = 0;
		while (!(want_error ? cal_error : cal_done) && n < limit)
		begin
			@(posedge pll_afi_clk);
			n++;
		end
		if (n >= limit)
		begin
			$display("%s: calibration did not finish within %0d cycles", test_name, limit);
			errors++;
		end
	endtask

	task automatic issue_read(rd_addr_t a);
		@(posedge pll_afi_clk);
		user_rd_strobe <= 1'b1;
		user_rd_addr <= a;
		exp_q.push_back(read_word(a));
		@(posedge pll_afi_clk);
		user_rd_strobe <= 1'b0;
	endtask

	task automatic wait_drain(int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit)
		begin
			@(posedge pll_afi_clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%s: %0d user reads never returned", test_name, exp_q.size());
			errors++;
		end
	endtask

	function automatic rd_addr_t random_addr();
		rd_addr_t a;
		a = rd_addr_t'($urandom);
		if (a == CAL_ADDR)
			a = a ^ rd_addr_t'(1);
		return a;
	endfunction

	task automatic reset_test();
		test_name = "reset";
		mem_latency = 8;
		reset_n <= 1'b0;
		repeat (3) @(posedge pll_afi_clk);
		check_bit("cal_done", 1'b0, cal_done);
		check_bit("cal_error", 1'b0, cal_error);
		check_bit("user_rd_valid", 1'b0, user_rd_valid);
		check_bit("read_enable", 1'b0, read_enable);
		check_bit("bus strobe", 1'b0, mem_rd_cmd.strobe);
		reset_n <= 1'b1;
		@(posedge pll_afi_clk);
		check_bit("cal_done", 1'b0, cal_done);
		check_bit("bus strobe", 1'b0, mem_rd_cmd.strobe);
	endtask

	task automatic calibration_test();
		test_name = "calibration";
		wait_cal(1'b0, CAL_LIMIT);
		check_bit("cal_error", 1'b0, cal_error);
	endtask

	task automatic user_read_test();
		test_name = "user_reads";
		// one expected word leaves the queue per beat, so a lost or doubled beat shows up
		for (int i = 0; i < 12; i++)
		begin
			issue_read(random_addr());
			repeat ($urandom % 3) @(posedge pll_afi_clk);
		end
		wait_drain(4 * CAL_WAIT);
	endtask

	task automatic collision_test();
		test_name = "collision";
		for (int i = 0; i < 3 * TRACK_INTERVAL / 6; i++)
		begin
			issue_read(random_addr());
			repeat (4) @(posedge pll_afi_clk);
		end
		// a strobe on every cycle for a whole interval must meet a tracking read
		for (int i = 0; i < TRACK_INTERVAL; i++)
		begin
			rd_addr_t a;
			a = random_addr();
			@(posedge pll_afi_clk);
			user_rd_strobe <= 1'b1;
			user_rd_addr <= a;
			exp_q.push_back(read_word(a));
		end
		@(posedge pll_afi_clk);
		user_rd_strobe <= 1'b0;
		wait_drain(4 * CAL_WAIT);
		check_bit("cal_error", 1'b0, cal_error);
	endtask

	task automatic long_latency_test();
		test_name = "long_latency";
		// past the deepest history tap, and each sweep beat is back
		// before the next sweep read reaches the bus
		mem_latency = 20;
		apply_reset();
		user_bus_cmds = 0;
		// strobes during the sweep and after the failure must be dropped
		for (int i = 0; i < CAL_LIMIT / 8; i++)
		begin
			@(posedge pll_afi_clk);
			user_rd_strobe <= ~user_rd_strobe;
			user_rd_addr <= random_addr();
			repeat (6) @(posedge pll_afi_clk);
		end
		user_rd_strobe <= 1'b0;
		wait_cal(1'b1, CAL_LIMIT);
		check_bit("cal_done", 1'b0, cal_done);
		check_bit("cal_error", 1'b1, cal_error);
		if (user_bus_cmds != 0)
		begin
			$display("%s: %0d user reads reached the bus before cal_done", test_name, user_bus_cmds);
			errors++;
		end
	endtask

	initial
	begin
		void'($urandom(32'hb40217d4));
		reset_n = 1'b0;
		user_rd_strobe = 1'b0;
		user_rd_addr = '0;
		mem_latency = 8;
		errors = 0;
		cycles = 0;
		user_bus_cmds = 0;
		test_name = "init";
		reset_test();
		calibration_test();
		user_read_test();
		collision_test();
		long_latency_test();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* project.f */
hw/qdr_phy_cfg_pkg.sv
hw/qdr_rd_types_pkg.sv
hw/read_latency_shifter.sv
hw/read_valid_selector.sv
hw/read_latency_calibrator.sv
hw/read_cmd_arbiter.sv
hw/read_data_router.sv
hw/qdr_read_path_top.sv
bench/qdr_read_path_properties.sv
bench/qdr_read_path_tb.sv

/* Makefile */
# Verilator build of the QDRII read path testbench

VERILATOR ?= verilator
TOP       ?= qdr_read_path_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_TEXT ?= PASS: all tests

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
